//--- cacc_tile.f
hdl/cacc_pkg.sv
hdl/cacc_if.sv
hdl/wh_link_adapter.sv
hdl/wh_concentrator.sv
hdl/cacc_io_endpoint.sv
hdl/cacc_vdp.sv
hdl/cacc_tile.sv
sim/cacc_tile_assert.sv
sim/cacc_tile_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cacc_tile_tb -f cacc_tile.f

# Raised error limit so that a failed link assertion reaches the testbench's own report
result=$(./obj_dir/Vcacc_tile_tb +verilator+error+limit+100 || true)
echo "$result"
echo "$result" | grep -qF -- '** PASS **'

//--- sim/cacc_tile_tb.sv
module cacc_tile_tb;
  import cacc_pkg::*;

  typedef struct packed
  {
    logic [3:0] op;
    word_t      addr;
    word_t      data;
    word_t      exp_val;
  } row_t;

  // Table-only opcode that reads reg_status until done is set
  localparam logic [3:0] op_poll_done = 4'hf;
  localparam cord_t tb_cord = 8'h01;
  localparam cord_t tile_cord = 8'h10;
  localparam cord_t mem_cord = 8'h20;

  logic  clk_i = 1'b0;
  logic  rst_n_i = 1'b0;
  cord_t my_cord_i = tile_cord;
  flit_t link_flit_i = '0;
  logic  link_v_i = 1'b0;
  logic  link_ready_o;
  flit_t link_flit_o;
  logic  link_v_o;
  logic  link_ready_i = 1'b0;

  word_t       mem [0:255];
  row_t        ops [$];
  flit_t       send_q [$];
  word_t       io_resp_q [$];
  word_t       exp_addr_q [$];
  flit_t       rx_hdr = '0;
  logic        rx_in_body = 1'b0;
  word_t       model_a_base = '0;
  word_t       model_b_base = '0;
  int          model_len = 0;
  logic        eng_busy = 1'b0;
  logic        table_built = 1'b0;
  int unsigned reset_count = 0;
  logic        link_checks_failed;

  cacc_tile #(.mem_cord_p(mem_cord)) UUT
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .my_cord_i(my_cord_i)
     ,.link_flit_i(link_flit_i), .link_v_i(link_v_i), .link_ready_o(link_ready_o)
     ,.link_flit_o(link_flit_o), .link_v_o(link_v_o), .link_ready_i(link_ready_i)
     );

  assign link_checks_failed = UUT.tile_checks.hold_fail || UUT.tile_checks.reset_fail
                              || UUT.tile_checks.known_fail;

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    if (reset_count < 3)
      reset_count <= reset_count + 1;
    if (reset_count == 2)
      rst_n_i <= 1'b1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic flit_t build_header(input logic [3:0] op, input cord_t dst, input cid_t cid,
                                         input len_t len, input cord_t src);
    return {6'b0, src, op, cid, dst, len};
  endfunction

  // Wrapping 32-bit sum of the signed 64-bit products
  function automatic word_t expected_dot(input word_t a_base, input word_t b_base, input int n);
    word_t  acc;
    word_t  a_addr;
    word_t  b_addr;
    longint av;
    longint bv;
    longint prod;
    acc = '0;
    for (int i = 0; i < n; i++)
    begin
      a_addr = a_base + word_t'(4 * i);
      b_addr = b_base + word_t'(4 * i);
      av = longint'(signed'(mem[a_addr[9:2]]));
      bv = longint'(signed'(mem[b_addr[9:2]]));
      prod = av * bv;
      acc = acc + prod[31:0];
    end
    return acc;
  endfunction

  function automatic void add_row(input logic [3:0] op, input word_t addr, input word_t data,
                                  input word_t exp_val);
    ops.push_back({op, addr, data, exp_val});
  endfunction

  function automatic void build_table();
    add_row(op_io_rd, reg_a_base, '0, '0);
    add_row(op_io_rd, reg_b_base, '0, '0);
    add_row(op_io_rd, reg_len, '0, '0);
    add_row(op_io_rd, reg_start, '0, '0);
    add_row(op_io_rd, reg_result, '0, '0);
    add_row(op_io_rd, reg_status, '0, '0);
    add_row(op_io_wr, reg_a_base, 32'h40, '0);
    add_row(op_io_wr, reg_b_base, 32'h200, '0);
    add_row(op_io_wr, reg_len, 32'd4, '0);
    add_row(op_io_rd, reg_a_base, '0, 32'h40);
    add_row(op_io_rd, reg_b_base, '0, 32'h200);
    add_row(op_io_rd, reg_len, '0, 32'd4);
    add_row(op_io_wr, reg_start, 32'd1, '0);
    add_row(op_poll_done, reg_status, '0, 32'h1);
    add_row(op_io_rd, reg_result, '0, expected_dot(32'h40, 32'h200, 4));
    add_row(op_io_wr, reg_len, 32'd0, '0);
    add_row(op_io_wr, reg_start, 32'd1, '0);
    add_row(op_io_rd, reg_status, '0, 32'h1);
    add_row(op_io_rd, reg_result, '0, '0);
    add_row(op_io_wr, reg_a_base, 32'h100, '0);
    add_row(op_io_wr, reg_b_base, 32'h380, '0);
    add_row(op_io_wr, reg_len, 32'd9, '0);
    add_row(op_io_wr, reg_start, 32'd1, '0);
    // These land while the engine is still fetching and so the second start is ignored
    add_row(op_io_rd, reg_a_base, '0, 32'h100);
    add_row(op_io_rd, reg_b_base, '0, 32'h380);
    add_row(op_io_wr, reg_start, 32'd1, '0);
    add_row(op_io_rd, reg_len, '0, 32'd9);
    add_row(op_poll_done, reg_status, '0, 32'h1);
    add_row(op_io_rd, reg_result, '0, expected_dot(32'h100, 32'h380, 9));
    add_row(op_io_rd, 32'h18, '0, '0);
  endfunction

  function automatic void track_write(input word_t addr, input word_t data);
    if (addr == reg_a_base)
      model_a_base = data;
    else if (addr == reg_b_base)
      model_b_base = data;
    else if (addr == reg_len)
      model_len = int'(data[15:0]);
    else if (addr == reg_start && !eng_busy)
    begin
      for (int i = 0; i < model_len; i++)
      begin
        exp_addr_q.push_back(model_a_base + word_t'(4 * i));
        exp_addr_q.push_back(model_b_base + word_t'(4 * i));
      end
      eng_busy = (model_len != 0);
    end
  endfunction

  task automatic drive_flit(input flit_t flit);
    link_flit_i <= flit;
    link_v_i <= 1'b1;
    @(negedge clk_i);
    while (!link_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic drive_packet();
    flit_t hdr;
    int    n;
    hdr = send_q.pop_front();
    n = int'(hdr[hdr_len_msb:hdr_len_lsb]);
    drive_flit(hdr);
    for (int i = 0; i < n; i++)
      drive_flit(send_q.pop_front());
    link_v_i <= 1'b0;
  endtask

  always @(posedge clk_i)
  begin
    if (rst_n_i && send_q.size() != 0)
      drive_packet();
  end

  // Roughly 30 percent of cycles stall the tile output
  always @(posedge clk_i)
  begin
    link_ready_i <= ($urandom_range(99) >= 30);
  end

  task automatic handle_packet(input flit_t hdr, input word_t data);
    word_t want;
    if (hdr[hdr_op_msb:hdr_op_lsb] == op_io_resp)
    begin
      assert (hdr == build_header(op_io_resp, tb_cord, cid_io, len_t'(1), tile_cord))
        else abort_run($sformatf("FAIL %0t: I/O response header %0h is wrong", $time, hdr));
      io_resp_q.push_back(data);
    end
    else if (hdr[hdr_op_msb:hdr_op_lsb] == op_mem_rd)
    begin
      assert (hdr == build_header(op_mem_rd, mem_cord, cid_mem, len_t'(1), tile_cord))
        else abort_run($sformatf("FAIL %0t: memory read header %0h is wrong", $time, hdr));
      assert (exp_addr_q.size() != 0)
        else abort_run("The engine issued a memory read that no running dot product needs");
      want = exp_addr_q.pop_front();
      assert (data == want)
        else abort_run($sformatf("FAIL %0t: memory read of %0h, expected %0h", $time, data, want));
      send_q.push_back(build_header(op_mem_resp, tile_cord, cid_mem, len_t'(1), mem_cord));
      send_q.push_back(mem[data[9:2]]);
    end
    else
      abort_run($sformatf("FAIL %0t: output packet with unknown opcode, header %0h", $time, hdr));
  endtask

  task automatic collect_flit(input flit_t flit);
    if (!rx_in_body)
    begin
      assert (flit[hdr_len_msb:hdr_len_lsb] == len_t'(1))
        else abort_run($sformatf("FAIL %0t: output header %0h has a bad length", $time, flit));
      rx_hdr = flit;
      rx_in_body = 1'b1;
    end
    else
    begin
      rx_in_body = 1'b0;
      handle_packet(rx_hdr, flit);
    end
  endtask

  always @(negedge clk_i)
  begin
    if (rst_n_i && link_v_o && link_ready_i)
      collect_flit(link_flit_o);
  end

  task automatic io_transaction(input logic [3:0] op, input word_t addr, input word_t data,
                                output word_t resp);
    if (op == op_io_wr)
    begin
      send_q.push_back(build_header(op, tile_cord, cid_io, len_t'(2), tb_cord));
      send_q.push_back(addr);
      send_q.push_back(data);
    end
    else
    begin
      send_q.push_back(build_header(op, tile_cord, cid_io, len_t'(1), tb_cord));
      send_q.push_back(addr);
    end
    while (io_resp_q.size() == 0)
      @(posedge clk_i);
    resp = io_resp_q.pop_front();
  endtask

  task automatic apply_row(input row_t row);
    word_t resp;
    resp = '0;
    if (row.op == op_poll_done)
    begin
      while (resp[0] == 1'b0)
        io_transaction(op_io_rd, reg_status, '0, resp);
      eng_busy = 1'b0;
    end
    else
    begin
      if (row.op == op_io_wr)
        track_write(row.addr, row.data);
      io_transaction(row.op, row.addr, row.data, resp);
    end
    assert (resp == row.exp_val)
      else abort_run($sformatf("FAIL %0t: op %0h at %0h returned %0h, expected %0h",
                               $time, row.op, row.addr, resp, row.exp_val));
  endtask

  always @(negedge clk_i)
  begin
    assert (!link_checks_failed)
      else abort_run("A concurrent assertion on the tile output link failed");
  end

  initial
  begin
    wait (table_built);
    repeat (2000 * ops.size())
      @(posedge clk_i);
    abort_run($sformatf("Timeout: the operation table did not finish within %0d cycles",
                        2000 * ops.size()));
  end

  initial
  begin : main
    void'($urandom(32'h5194_89b9));
    for (int i = 0; i < 256; i++)
      mem[8'(i)] = $urandom();
    build_table();
    table_built = 1'b1;
    wait (rst_n_i);
    foreach (ops[i])
      apply_row(ops[i]);
    assert (exp_addr_q.size() == 0)
      else abort_run("The engine finished without issuing every expected memory read");
    if (!link_checks_failed)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      abort_run("A concurrent assertion on the tile output link failed");
  end

endmodule

//--- sim/cacc_tile_assert.sv
module cacc_tile_assert
  (input  logic             clk_i
   , input  logic             rst_n_i
   , input  cacc_pkg::flit_t  flit_i
   , input  logic             v_i
   , input  logic             ready_i
   );

  logic hold_fail = 1'b0;
  logic reset_fail = 1'b0;
  logic known_fail = 1'b0;

  // A stalled flit stays on the link until the receiver takes it
  out_holds_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      v_i && !ready_i |=> v_i && $stable(flit_i))
    else
    begin
      $error("tile output flit or valid changed while the link was stalled");
      hold_fail = 1'b1;
    end

  out_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !v_i)
    else
    begin
      $error("tile output valid was high during reset");
      reset_fail = 1'b1;
    end

  out_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown(v_i))
    else
    begin
      $error("tile output valid is unknown");
      known_fail = 1'b1;
    end

endmodule

bind cacc_tile cacc_tile_assert tile_checks
  (.clk_i(clk_i), .rst_n_i(rst_n_i), .flit_i(link_flit_o), .v_i(link_v_o)
   ,.ready_i(link_ready_i));

//--- hdl/cacc_tile.sv
module cacc_tile
  #(parameter cacc_pkg::cord_t mem_cord_p = 8'h20
   )
  (input  logic             clk_i
   , input  logic             rst_n_i

   , input  cacc_pkg::cord_t  my_cord_i

   , input  cacc_pkg::flit_t  link_flit_i
   , input  logic             link_v_i
   , output logic             link_ready_o

   , output cacc_pkg::flit_t  link_flit_o
   , output logic             link_v_o
   , input  logic             link_ready_i
   );
  import cacc_pkg::*;

  pkt_t io_cmd_pkt;
  logic io_cmd_v;
  logic io_cmd_ready;
  pkt_t io_resp_pkt;
  logic io_resp_v;
  logic io_resp_ready;
  pkt_t mem_req_pkt;
  logic mem_req_v;
  logic mem_req_ready;
  pkt_t mem_resp_pkt;
  logic mem_resp_v;
  logic mem_resp_ready;

  wh_link_if  link_io ();
  wh_link_if  link_mem ();
  cacc_csr_if csr ();

  wh_concentrator concentrator
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     ,.link_flit_i(link_flit_i), .link_v_i(link_v_i), .link_ready_o(link_ready_o)
     ,.link_flit_o(link_flit_o), .link_v_o(link_v_o), .link_ready_i(link_ready_i)
     ,.cl_io(link_io.hub), .cl_mem(link_mem.hub)
     );

  // I/O commands arrive on rx, their responses leave on tx
  wh_link_adapter io_adapter
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .link(link_io.client)
     ,.tx_pkt_i(io_resp_pkt), .tx_v_i(io_resp_v), .tx_ready_o(io_resp_ready)
     ,.rx_pkt_o(io_cmd_pkt), .rx_v_o(io_cmd_v), .rx_ready_i(io_cmd_ready)
     );

  wh_link_adapter mem_adapter
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .link(link_mem.client)
     ,.tx_pkt_i(mem_req_pkt), .tx_v_i(mem_req_v), .tx_ready_o(mem_req_ready)
     ,.rx_pkt_o(mem_resp_pkt), .rx_v_o(mem_resp_v), .rx_ready_i(mem_resp_ready)
     );

  cacc_io_endpoint io_endpoint
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .my_cord_i(my_cord_i)
     ,.cmd_pkt_i(io_cmd_pkt), .cmd_v_i(io_cmd_v), .cmd_ready_o(io_cmd_ready)
     ,.resp_pkt_o(io_resp_pkt), .resp_v_o(io_resp_v), .resp_ready_i(io_resp_ready)
     ,.csr(csr.master)
     );

  cacc_vdp #(.mem_cord_p(mem_cord_p)) vdp
    (.clk_i(clk_i), .rst_n_i(rst_n_i), .my_cord_i(my_cord_i), .csr(csr.slave)
     ,.mem_req_pkt_o(mem_req_pkt), .mem_req_v_o(mem_req_v), .mem_req_ready_i(mem_req_ready)
     ,.mem_resp_pkt_i(mem_resp_pkt), .mem_resp_v_i(mem_resp_v)
     ,.mem_resp_ready_o(mem_resp_ready)
     );

endmodule

//--- hdl/cacc_vdp.sv
module cacc_vdp
  #(parameter cacc_pkg::cord_t mem_cord_p = 8'h20
   )
  (input  logic             clk_i
   , input  logic             rst_n_i

   , input  cacc_pkg::cord_t  my_cord_i

   , cacc_csr_if.slave        csr

   , output cacc_pkg::pkt_t   mem_req_pkt_o
   , output logic             mem_req_v_o
   , input  logic             mem_req_ready_i

   , input  cacc_pkg::pkt_t   mem_resp_pkt_i
   , input  logic             mem_resp_v_i
   , output logic             mem_resp_ready_o
   );
  import cacc_pkg::*;

  typedef enum logic [2:0] {s_idle, s_req_a, s_wait_a, s_req_b, s_wait_b, s_acc} vdp_state_e;

  vdp_state_e  state_q;
  word_t       a_base_q;
  word_t       b_base_q;
  logic [15:0] len_q;
  logic [15:0] idx_q;
  word_t       result_q;
  logic        done_q;
  word_t       a_word_q;
  word_t       b_word_q;
  word_t       req_addr;
  word_t       product;
  logic        busy;
  logic        start;

  assign busy = (state_q != s_idle);
  assign start = csr.wr_en && (csr.addr == reg_start) && !busy;

  always_comb
  begin
    csr.rdata = '0;
    if (csr.rd_en)
    begin
      case (csr.addr)
        reg_a_base: csr.rdata = a_base_q;
        reg_b_base: csr.rdata = b_base_q;
        reg_len:    csr.rdata = word_t'(len_q);
        reg_result: csr.rdata = result_q;
        reg_status: csr.rdata = {30'b0, busy, done_q};
        default:    csr.rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      a_base_q <= '0;
      b_base_q <= '0;
      len_q <= '0;
    end
    else if (csr.wr_en)
    begin
      case (csr.addr)
        reg_a_base: a_base_q <= csr.wdata;
        reg_b_base: b_base_q <= csr.wdata;
        reg_len:    len_q <= csr.wdata[15:0];
        default:    ;
      endcase
    end
  end

  // Element i of each vector sits at its base plus 4*i
  assign req_addr = ((state_q == s_req_b) ? b_base_q : a_base_q) + word_t'({idx_q, 2'b00});
  assign mem_req_v_o = (state_q == s_req_a) || (state_q == s_req_b);
  assign mem_req_pkt_o = {word_t'(0), req_addr,
                          make_hdr(op_mem_rd, mem_cord_p, cid_mem, len_t'(1), my_cord_i)};
  assign mem_resp_ready_o = (state_q == s_wait_a) || (state_q == s_wait_b);

  // Only the low 32 bits of the signed product are kept
  assign product = $signed(a_word_q) * $signed(b_word_q);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= s_idle;
      idx_q <= '0;
      result_q <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        s_idle:
        begin
          if (start)
          begin
            idx_q <= '0;
            result_q <= '0;
            done_q <= (len_q == '0);
            state_q <= (len_q == '0) ? s_idle : s_req_a;
          end
        end
        s_req_a:  if (mem_req_ready_i) state_q <= s_wait_a;
        s_wait_a: if (mem_resp_v_i) state_q <= s_req_b;
        s_req_b:  if (mem_req_ready_i) state_q <= s_wait_b;
        s_wait_b: if (mem_resp_v_i) state_q <= s_acc;
        s_acc:
        begin
          result_q <= result_q + product;
          idx_q <= idx_q + 16'd1;
          if (idx_q + 16'd1 >= len_q)
          begin
            done_q <= 1'b1;
            state_q <= s_idle;
          end
          else
            state_q <= s_req_a;
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_resp_v_i && mem_resp_ready_o)
    begin
      if (state_q == s_wait_a)
        a_word_q <= mem_resp_pkt_i[2*$bits(word_t)-1:$bits(word_t)];
      else
        b_word_q <= mem_resp_pkt_i[2*$bits(word_t)-1:$bits(word_t)];
    end
  end

endmodule

//--- hdl/cacc_io_endpoint.sv
module cacc_io_endpoint
  (input  logic             clk_i
   , input  logic             rst_n_i

   , input  cacc_pkg::cord_t  my_cord_i

   , input  cacc_pkg::pkt_t   cmd_pkt_i
   , input  logic             cmd_v_i
   , output logic             cmd_ready_o

   , output cacc_pkg::pkt_t   resp_pkt_o
   , output logic             resp_v_o
   , input  logic             resp_ready_i

   , cacc_csr_if.master       csr
   );
  import cacc_pkg::*;

  logic       accept;
  logic [3:0] cmd_op;
  cord_t      cmd_src;
  word_t      resp_data;
  flit_t      resp_hdr;
  logic       resp_v_q;
  pkt_t       resp_pkt_q;

  // Only one command is in flight and the next waits until its response is taken
  assign cmd_ready_o = !resp_v_q;
  assign accept = cmd_v_i && cmd_ready_o;

  assign cmd_op = cmd_pkt_i[hdr_op_msb:hdr_op_lsb];
  assign cmd_src = cmd_pkt_i[hdr_src_msb:hdr_src_lsb];

  assign csr.wr_en = accept && (cmd_op == op_io_wr);
  assign csr.rd_en = accept && (cmd_op == op_io_rd);
  assign csr.addr = cmd_pkt_i[2*$bits(word_t)-1:$bits(word_t)];
  assign csr.wdata = cmd_pkt_i[3*$bits(word_t)-1:2*$bits(word_t)];

  // Writes and unknown opcodes are acknowledged with zero data
  assign resp_data = csr.rd_en ? csr.rdata : '0;
  assign resp_hdr = make_hdr(op_io_resp, cmd_src, cid_io, len_t'(1), my_cord_i);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_v_q && resp_ready_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_pkt_q <= {word_t'(0), resp_data, resp_hdr};
  end

  assign resp_v_o = resp_v_q;
  assign resp_pkt_o = resp_pkt_q;

endmodule

//--- hdl/wh_concentrator.sv
module wh_concentrator
  (input  logic             clk_i
   , input  logic             rst_n_i

   , input  cacc_pkg::flit_t  link_flit_i
   , input  logic             link_v_i
   , output logic             link_ready_o

   , output cacc_pkg::flit_t  link_flit_o
   , output logic             link_v_o
   , input  logic             link_ready_i

   , wh_link_if.hub           cl_io
   , wh_link_if.hub           cl_mem
   );
  import cacc_pkg::*;

  logic out_busy_q;
  logic out_owner_q;
  logic out_body_q;
  len_t out_rem_q;
  logic rr_last_q;
  logic pick;
  logic sel;
  logic out_last;
  logic in_body_q;
  len_t in_rem_q;
  cid_t in_cid_q;
  cid_t steer;
  logic in_last;

  // Select 0 is the I/O client, 1 the memory client
  assign pick = (cl_io.out_v && cl_mem.out_v) ? !rr_last_q : cl_mem.out_v;
  assign sel = out_busy_q ? out_owner_q : pick;
  assign link_flit_o = sel ? cl_mem.out_flit : cl_io.out_flit;
  assign link_v_o = sel ? cl_mem.out_v : cl_io.out_v;
  assign cl_io.out_ready = !sel && link_ready_i;
  assign cl_mem.out_ready = sel && link_ready_i;
  assign out_last = out_body_q ? (out_rem_q == len_t'(1))
                               : (link_flit_o[hdr_len_msb:hdr_len_lsb] == '0);

  // The grant locks as soon as a header is shown, so a stalled flit never changes
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      out_busy_q <= 1'b0;
      out_owner_q <= 1'b0;
      out_body_q <= 1'b0;
      out_rem_q <= '0;
      rr_last_q <= 1'b1;
    end
    else if (link_v_o)
    begin
      out_owner_q <= sel;
      out_busy_q <= !(link_ready_i && out_last);
      if (link_ready_i)
      begin
        if (out_last)
        begin
          out_body_q <= 1'b0;
          rr_last_q <= sel;
        end
        else if (!out_body_q)
        begin
          out_body_q <= 1'b1;
          out_rem_q <= link_flit_o[hdr_len_msb:hdr_len_lsb];
        end
        else
          out_rem_q <= out_rem_q - 1'b1;
      end
    end
  end

  assign steer = in_body_q ? in_cid_q : link_flit_i[hdr_cid_msb:hdr_cid_lsb];
  assign cl_io.in_flit = link_flit_i;
  assign cl_mem.in_flit = link_flit_i;
  assign cl_io.in_v = link_v_i && (steer == cid_io);
  assign cl_mem.in_v = link_v_i && (steer == cid_mem);
  assign in_last = in_body_q ? (in_rem_q == len_t'(1))
                             : (link_flit_i[hdr_len_msb:hdr_len_lsb] == '0);

  always_comb
  begin
    case (steer)
      cid_io:  link_ready_o = cl_io.in_ready;
      cid_mem: link_ready_o = cl_mem.in_ready;
      // Packets for an unknown client are drained
      default: link_ready_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      in_body_q <= 1'b0;
      in_rem_q <= '0;
      in_cid_q <= '0;
    end
    else if (link_v_i && link_ready_o)
    begin
      if (in_last)
        in_body_q <= 1'b0;
      else if (!in_body_q)
      begin
        in_body_q <= 1'b1;
        in_rem_q <= link_flit_i[hdr_len_msb:hdr_len_lsb];
        in_cid_q <= link_flit_i[hdr_cid_msb:hdr_cid_lsb];
      end
      else
        in_rem_q <= in_rem_q - 1'b1;
    end
  end

endmodule

//--- hdl/wh_link_adapter.sv
module wh_link_adapter
  (input  logic            clk_i
   , input  logic            rst_n_i

   , wh_link_if.client       link

   , input  cacc_pkg::pkt_t  tx_pkt_i
   , input  logic            tx_v_i
   , output logic            tx_ready_o

   , output cacc_pkg::pkt_t  rx_pkt_o
   , output logic            rx_v_o
   , input  logic            rx_ready_i
   );
  import cacc_pkg::*;

  typedef enum logic [1:0] {st_idle, st_send, st_hold} adp_state_e;

  adp_state_e tx_state_q;
  adp_state_e rx_state_q;
  pkt_t       tx_shift_q;
  len_t       tx_left_q;
  pkt_t       rx_buf_q;
  len_t       rx_idx_q;
  len_t       rx_len_q;
  len_t       in_len;
  logic       tx_take;
  logic       flit_sent;
  logic       flit_got;
  logic       rx_last;

  assign tx_ready_o = (tx_state_q == st_idle);
  assign tx_take = tx_v_i && tx_ready_o;
  assign link.out_v = (tx_state_q == st_send);
  assign link.out_flit = tx_shift_q[$bits(flit_t)-1:0];
  assign flit_sent = link.out_v && link.out_ready;

  // tx_left_q counts the data flits still behind the one on the link
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      tx_state_q <= st_idle;
      tx_left_q <= '0;
    end
    else if (tx_take)
    begin
      tx_state_q <= st_send;
      tx_left_q <= tx_pkt_i[hdr_len_msb:hdr_len_lsb];
    end
    else if (flit_sent)
    begin
      if (tx_left_q == '0)
        tx_state_q <= st_idle;
      else
        tx_left_q <= tx_left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (tx_take)
      tx_shift_q <= tx_pkt_i;
    else if (flit_sent)
      tx_shift_q <= tx_shift_q >> $bits(flit_t);
  end

  assign in_len = link.in_flit[hdr_len_msb:hdr_len_lsb];
  assign link.in_ready = (rx_state_q != st_hold);
  assign flit_got = link.in_v && link.in_ready;
  assign rx_last = (rx_idx_q == '0) ? (in_len == '0) : (rx_idx_q == rx_len_q);
  assign rx_v_o = (rx_state_q == st_hold);
  assign rx_pkt_o = rx_buf_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rx_state_q <= st_idle;
      rx_idx_q <= '0;
      rx_len_q <= '0;
    end
    else if (rx_v_o && rx_ready_i)
      rx_state_q <= st_idle;
    else if (flit_got)
    begin
      if (rx_idx_q == '0)
        rx_len_q <= in_len;
      if (rx_last)
      begin
        rx_state_q <= st_hold;
        rx_idx_q <= '0;
      end
      else
        rx_idx_q <= rx_idx_q + 1'b1;
    end
  end

  // The header clears the buffer so that unused data words read as zero
  always_ff @(posedge clk_i)
  begin
    if (flit_got)
    begin
      if (rx_idx_q == '0)
        rx_buf_q <= pkt_t'(link.in_flit);
      else if (rx_idx_q < len_t'(pkt_flits))
        rx_buf_q[rx_idx_q*$bits(flit_t) +: $bits(flit_t)] <= link.in_flit;
    end
  end

endmodule

//--- hdl/cacc_if.sv
// The in_* signals flow from the hub to the client, out_* from the client to the hub
interface wh_link_if;
  import cacc_pkg::*;

  flit_t in_flit;
  logic  in_v;
  logic  in_ready;
  flit_t out_flit;
  logic  out_v;
  logic  out_ready;

  modport client (input in_flit, input in_v, output in_ready,
                  output out_flit, output out_v, input out_ready);

  modport hub (output in_flit, output in_v, input in_ready,
               input out_flit, input out_v, output out_ready);

endinterface

interface cacc_csr_if;
  import cacc_pkg::*;

  logic  wr_en;
  logic  rd_en;
  word_t addr;
  word_t wdata;
  word_t rdata;

  modport master (output wr_en, output rd_en, output addr, output wdata, input rdata);

  modport slave (input wr_en, input rd_en, input addr, input wdata, output rdata);

endinterface

//--- hdl/cacc_pkg.sv
package cacc_pkg;

  localparam int pkt_flits = 3;

  typedef logic [31:0] flit_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0] cord_t;
  typedef logic [1:0] cid_t;
  typedef logic [3:0] len_t;
  typedef logic [pkt_flits*32-1:0] pkt_t;

  // Header flit layout
  localparam int hdr_len_lsb = 0;
  localparam int hdr_len_msb = 3;
  localparam int hdr_dst_lsb = 4;
  localparam int hdr_dst_msb = 11;
  localparam int hdr_cid_lsb = 12;
  localparam int hdr_cid_msb = 13;
  localparam int hdr_op_lsb = 14;
  localparam int hdr_op_msb = 17;
  localparam int hdr_src_lsb = 18;
  localparam int hdr_src_msb = 25;

  localparam logic [3:0] op_io_wr = 4'h1;
  localparam logic [3:0] op_io_rd = 4'h2;
  localparam logic [3:0] op_io_resp = 4'h3;
  localparam logic [3:0] op_mem_rd = 4'h4;
  localparam logic [3:0] op_mem_resp = 4'h5;

  localparam cid_t cid_io = 2'd0;
  localparam cid_t cid_mem = 2'd1;

  localparam word_t reg_a_base = 32'h00;
  localparam word_t reg_b_base = 32'h04;
  localparam word_t reg_len = 32'h08;
  localparam word_t reg_start = 32'h0C;
  localparam word_t reg_result = 32'h10;
  localparam word_t reg_status = 32'h14;

  function automatic flit_t make_hdr(input logic [3:0] op, input cord_t dst, input cid_t cid,
                                     input len_t len, input cord_t src);
    flit_t hdr;
    hdr = '0;
    hdr[hdr_len_msb:hdr_len_lsb] = len;
    hdr[hdr_dst_msb:hdr_dst_lsb] = dst;
    hdr[hdr_cid_msb:hdr_cid_lsb] = cid;
    hdr[hdr_op_msb:hdr_op_lsb] = op;
    hdr[hdr_src_msb:hdr_src_lsb] = src;
    return hdr;
  endfunction

endpackage
